//--- hw/dbg_pkg.sv
package dbg_pkg;

	////////////////////
	// basic types
	////////////////////
	typedef logic [31:0] word_t;
	typedef logic [7:0]  byte_t;
	typedef logic [2:0]  reg_idx_t;   // r0 is hardwired to zero

	localparam int N_REGS = 8;

	// opcode lives in instr[31:28]
	typedef enum logic [3:0] {
		OP_ADDI = 4'd0,   // rd = rs + sext(imm16)
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,   // rd = rs - rt
		OP_XOR  = 4'd3,
		OP_HALT = 4'd15
	} opcode_e;

	// host command bytes, plain ascii
	typedef enum logic [7:0] {
		CMD_LOAD = 8'h4c,   // 'L'
		CMD_RUN  = 8'h52,   // 'R'
		CMD_STEP = 8'h53    // 'S'
	} cmd_e;

	// dump is r0..r7, pc, cycle count, each word lsb first
	localparam int DUMP_WORDS = 10;
	localparam int DUMP_BYTES = DUMP_WORDS * 4;

	////////////////////
	// field extraction
	////////////////////
	function automatic reg_idx_t rd_of(word_t instr);
		return instr[26:24];
	endfunction

	function automatic reg_idx_t rs_of(word_t instr);
		return instr[22:20];
	endfunction

	function automatic reg_idx_t rt_of(word_t instr);
		return instr[18:16];
	endfunction

	function automatic word_t imm_of(word_t instr);
		return {{16{instr[15]}}, instr[15:0]};   // sign extended
	endfunction

endpackage

//--- hw/uart_rx.sv
module uart_rx #(
	parameter int CLKS_PER_BIT = 868
) (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           rx,
	output dbg_pkg::byte_t rx_data,
	output logic           rx_done
);

	localparam int CW = $clog2(CLKS_PER_BIT);

	typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_e;

	state_e         state;
	logic [1:0]     sync;       // metastability guard on the line
	logic [CW-1:0]  cnt;
	logic [2:0]     bit_idx;
	dbg_pkg::byte_t shift;
	logic           rx_s;

	assign rx_s    = sync[1];
	assign rx_data = shift;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			sync <= 2'b11;   // line idles high
		else
			sync <= {sync[0], rx};
	end

	////////////////////
	// frame FSM
	////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= S_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			case (state)
				S_IDLE: begin
					cnt <= '0;
					if (!rx_s)
						state <= S_START;
				end
				S_START: begin
					if (cnt == CW'(CLKS_PER_BIT / 2 - 1)) begin
						cnt     <= '0;
						bit_idx <= '0;
						state   <= rx_s ? S_IDLE : S_DATA;   // glitch, back to idle
					end else
						cnt <= cnt + 1'b1;
				end
				S_DATA: begin
					if (cnt == CW'(CLKS_PER_BIT - 1)) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= S_STOP;
					end else
						cnt <= cnt + 1'b1;
				end
				S_STOP: begin
					// middle of stop bit, no framing check
					if (cnt == CW'(CLKS_PER_BIT - 1)) begin
						rx_done <= 1'b1;
						state   <= S_IDLE;
					end else
						cnt <= cnt + 1'b1;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge clk) begin
		if (state == S_DATA && cnt == CW'(CLKS_PER_BIT - 1))
			shift <= {rx_s, shift[7:1]};
	end

endmodule

//--- hw/uart_tx.sv
module uart_tx #(
	parameter int CLKS_PER_BIT = 868
) (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           tx_start,
	input  dbg_pkg::byte_t tx_data,
	output logic           tx,
	output logic           tx_done
);

	localparam int CW = $clog2(CLKS_PER_BIT);

	logic          busy;
	logic [CW-1:0] cnt;
	logic [3:0]    nbit;    // 0 start, 1..8 data, 9 stop
	logic [9:0]    frame;

	assign tx = busy ? frame[0] : 1'b1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy    <= 1'b0;
			cnt     <= '0;
			nbit    <= '0;
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (!busy) begin
				cnt  <= '0;
				nbit <= '0;
				if (tx_start)
					busy <= 1'b1;
			end else if (cnt == CW'(CLKS_PER_BIT - 1)) begin
				cnt <= '0;
				if (nbit == 4'd9) begin
					busy    <= 1'b0;
					tx_done <= 1'b1;   // stop bit just ended
				end else
					nbit <= nbit + 1'b1;
			end else
				cnt <= cnt + 1'b1;
		end
	end

	////////////////////
	// shift register
	////////////////////
	always_ff @(posedge clk) begin
		if (!busy && tx_start)
			frame <= {1'b1, tx_data, 1'b0};
		else if (busy && cnt == CW'(CLKS_PER_BIT - 1))
			frame <= {1'b1, frame[9:1]};
	end

endmodule

//--- hw/inst_mem.sv
module inst_mem #(
	parameter int  IMEM_DEPTH = 32,
	localparam int AW         = $clog2(IMEM_DEPTH)
) (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           we,
	input  logic [AW-1:0]  waddr,
	input  dbg_pkg::word_t wdata,
	input  logic [AW-1:0]  raddr,
	output dbg_pkg::word_t rdata
);

	localparam dbg_pkg::word_t HALT_WORD = {dbg_pkg::OP_HALT, 28'd0};

	dbg_pkg::word_t mem [IMEM_DEPTH];

	// reset fills with halt so an empty program stops at once
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < IMEM_DEPTH; i++)
				mem[i] <= HALT_WORD;
		end else if (we) begin
			mem[waddr] <= wdata;
		end
	end

	assign rdata = mem[raddr];   // async read

endmodule

//--- hw/mini_core.sv
module mini_core #(
	parameter int  IMEM_DEPTH = 32,
	localparam int AW         = $clog2(IMEM_DEPTH)
) (
	input  logic                                 clk,
	input  logic                                 arst_n,
	input  logic                                 en,
	input  logic                                 clear,
	input  dbg_pkg::word_t                       instr,
	output logic [AW-1:0]                        pc,
	output logic                                 halted,
	output dbg_pkg::word_t [dbg_pkg::N_REGS-1:0] reg_dump
);

	dbg_pkg::word_t [dbg_pkg::N_REGS-1:0] regs;

	dbg_pkg::opcode_e  op;
	dbg_pkg::reg_idx_t rd;
	dbg_pkg::reg_idx_t rs;
	dbg_pkg::reg_idx_t rt;
	dbg_pkg::word_t    imm;
	dbg_pkg::word_t    src_a;
	dbg_pkg::word_t    src_b;
	dbg_pkg::word_t    result;
	logic              wr_en;
	logic              exec;

	////////////////////
	// decode
	////////////////////
	assign op  = dbg_pkg::opcode_e'(instr[31:28]);
	assign rd  = dbg_pkg::rd_of(instr);
	assign rs  = dbg_pkg::rs_of(instr);
	assign rt  = dbg_pkg::rt_of(instr);
	assign imm = dbg_pkg::imm_of(instr);

	assign src_a = regs[rs];
	assign src_b = regs[rt];

	always_comb begin
		result = '0;
		wr_en  = 1'b0;
		case (op)
			dbg_pkg::OP_ADDI: begin
				result = src_a + imm;
				wr_en  = 1'b1;
			end
			dbg_pkg::OP_ADD: begin
				result = src_a + src_b;
				wr_en  = 1'b1;
			end
			dbg_pkg::OP_SUB: begin
				result = src_a - src_b;
				wr_en  = 1'b1;
			end
			dbg_pkg::OP_XOR: begin
				result = src_a ^ src_b;
				wr_en  = 1'b1;
			end
			default: ;   // halt and unknown opcodes write nothing
		endcase
	end

	assign exec = en && !halted;

	////////////////////
	// state update
	////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc     <= '0;
			halted <= 1'b0;
			regs   <= '0;
		end else if (clear) begin
			pc     <= '0;   // registers survive a reload
			halted <= 1'b0;
		end else if (exec) begin
			if (op == dbg_pkg::OP_HALT) begin
				halted <= 1'b1;   // pc stays on the halt
			end else begin
				pc <= pc + 1'b1;
				if (wr_en && rd != '0)
					regs[rd] <= result;
			end
		end
	end

	assign reg_dump = regs;

endmodule

//--- hw/debug_unit.sv
module debug_unit #(
	parameter int  IMEM_DEPTH = 32,
	localparam int AW         = $clog2(IMEM_DEPTH)
) (
	input  logic                                 clk,
	input  logic                                 arst_n,
	input  dbg_pkg::byte_t                       rx_data,
	input  logic                                 rx_done,
	input  logic                                 tx_done,
	input  logic                                 halted,
	input  logic [AW-1:0]                        pc,
	input  dbg_pkg::word_t [dbg_pkg::N_REGS-1:0] reg_dump,
	output dbg_pkg::byte_t                       tx_data,
	output logic                                 tx_start,
	output logic                                 imem_we,
	output logic [AW-1:0]                        imem_addr,
	output dbg_pkg::word_t                       imem_wdata,
	output logic                                 core_en,
	output logic                                 core_clear
);

	typedef enum logic [2:0] {
		S_IDLE, S_LOAD_CNT, S_LOAD_BYTES, S_RUN, S_STEP, S_DUMP_SEL, S_DUMP_WAIT
	} state_e;

	state_e         state;
	dbg_pkg::byte_t words_left;
	logic [AW-1:0]  load_addr;
	logic [1:0]     load_byte;
	dbg_pkg::word_t word_buf;
	dbg_pkg::word_t cycle_cnt;
	logic [3:0]     word_idx;
	logic [1:0]     byte_idx;
	dbg_pkg::word_t dump_word;

	assign core_en    = (state == S_RUN || state == S_STEP) && !halted;
	assign tx_start   = (state == S_DUMP_SEL);   // one cycle, uart is idle here
	assign imem_addr  = load_addr;
	assign imem_wdata = word_buf;

	////////////////////
	// main FSM
	////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= S_IDLE;
			words_left <= '0;
			load_addr  <= '0;
			load_byte  <= '0;
			cycle_cnt  <= '0;
			word_idx   <= '0;
			byte_idx   <= '0;
			imem_we    <= 1'b0;
			core_clear <= 1'b0;
		end else begin
			imem_we    <= 1'b0;
			core_clear <= 1'b0;
			if (core_en)
				cycle_cnt <= cycle_cnt + 1'b1;   // counts the halt cycle too
			case (state)
				S_IDLE: begin
					if (rx_done) begin
						case (dbg_pkg::cmd_e'(rx_data))
							dbg_pkg::CMD_LOAD: state <= S_LOAD_CNT;
							dbg_pkg::CMD_RUN: begin
								cycle_cnt <= '0;
								state     <= halted ? S_DUMP_SEL : S_RUN;
							end
							dbg_pkg::CMD_STEP: begin
								cycle_cnt <= '0;
								state     <= halted ? S_DUMP_SEL : S_STEP;
							end
							default: ;   // unknown byte, stay quiet
						endcase
					end
				end
				S_LOAD_CNT: begin
					if (rx_done) begin
						words_left <= rx_data;
						load_addr  <= '0;
						load_byte  <= '0;
						if (rx_data == '0) begin
							core_clear <= 1'b1;
							state      <= S_IDLE;
						end else
							state <= S_LOAD_BYTES;
					end
				end
				S_LOAD_BYTES: begin
					if (rx_done) begin
						load_byte <= load_byte + 1'b1;
						if (load_byte == 2'd3)
							imem_we <= 1'b1;   // word complete
					end
					if (imem_we) begin
						load_addr  <= load_addr + 1'b1;
						words_left <= words_left - 1'b1;
						if (words_left == 8'd1) begin
							core_clear <= 1'b1;
							state      <= S_IDLE;
						end
					end
				end
				S_RUN: begin
					if (halted)
						state <= S_DUMP_SEL;
				end
				S_STEP:     state <= S_DUMP_SEL;
				S_DUMP_SEL: state <= S_DUMP_WAIT;
				S_DUMP_WAIT: begin
					if (tx_done) begin
						byte_idx <= byte_idx + 1'b1;
						if (byte_idx == 2'd3) begin
							if (word_idx == 4'(dbg_pkg::DUMP_WORDS - 1)) begin
								word_idx <= '0;
								state    <= S_IDLE;
							end else begin
								word_idx <= word_idx + 1'b1;
								state    <= S_DUMP_SEL;
							end
						end else
							state <= S_DUMP_SEL;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// load bytes arrive lsb first
	always_ff @(posedge clk) begin
		if (state == S_LOAD_BYTES && rx_done)
			word_buf <= {rx_data, word_buf[31:8]};
	end

	////////////////////
	// dump byte select
	////////////////////
	always_comb begin
		if (word_idx < 4'(dbg_pkg::N_REGS))
			dump_word = reg_dump[word_idx[2:0]];
		else if (word_idx == 4'(dbg_pkg::N_REGS))
			dump_word = dbg_pkg::word_t'(pc);   // zero extended
		else
			dump_word = cycle_cnt;
		tx_data = dump_word[{byte_idx, 3'b000} +: 8];
	end

endmodule

//--- hw/debug_top.sv
module debug_top #(
	parameter int CLKS_PER_BIT = 868,
	parameter int IMEM_DEPTH   = 32
) (
	input  logic clk,
	input  logic arst_n,
	input  logic rx,
	output logic tx
);

	localparam int AW = $clog2(IMEM_DEPTH);

	dbg_pkg::byte_t                       rx_data;
	logic                                 rx_done;
	dbg_pkg::byte_t                       tx_data;
	logic                                 tx_start;
	logic                                 tx_done;
	logic                                 imem_we;
	logic [AW-1:0]                        imem_addr;
	dbg_pkg::word_t                       imem_wdata;
	dbg_pkg::word_t                       instr;
	logic [AW-1:0]                        pc;
	logic                                 halted;
	dbg_pkg::word_t [dbg_pkg::N_REGS-1:0] reg_dump;
	logic                                 core_en;
	logic                                 core_clear;

	////////////////////
	// serial side
	////////////////////
	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_rx (
		.clk     (clk),
		.arst_n  (arst_n),
		.rx      (rx),
		.rx_data (rx_data),
		.rx_done (rx_done)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx (
		.clk      (clk),
		.arst_n   (arst_n),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx       (tx),
		.tx_done  (tx_done)
	);

	debug_unit #(.IMEM_DEPTH(IMEM_DEPTH)) i_debug_unit (
		.clk        (clk),
		.arst_n     (arst_n),
		.rx_data    (rx_data),
		.rx_done    (rx_done),
		.tx_done    (tx_done),
		.halted     (halted),
		.pc         (pc),
		.reg_dump   (reg_dump),
		.tx_data    (tx_data),
		.tx_start   (tx_start),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.core_en    (core_en),
		.core_clear (core_clear)
	);

	////////////////////
	// processor side
	////////////////////
	inst_mem #(.IMEM_DEPTH(IMEM_DEPTH)) i_inst_mem (
		.clk    (clk),
		.arst_n (arst_n),
		.we     (imem_we),
		.waddr  (imem_addr),
		.wdata  (imem_wdata),
		.raddr  (pc),
		.rdata  (instr)
	);

	mini_core #(.IMEM_DEPTH(IMEM_DEPTH)) i_mini_core (
		.clk      (clk),
		.arst_n   (arst_n),
		.en       (core_en),
		.clear    (core_clear),
		.instr    (instr),
		.pc       (pc),
		.halted   (halted),
		.reg_dump (reg_dump)
	);

endmodule

//--- testbench/debug_top_asserts.sv
module debug_top_asserts (
	input logic clk,
	input logic arst_n,
	input logic tx_start,
	input logic tx_done,
	input logic core_en,
	input logic core_clear,
	input logic halted,
	input logic imem_we,
	input logic in_load
);
	timeunit 1ns;
	timeprecision 1ps;

	int   fail_count = 0;   // assertion failures seen so far
	logic in_flight;        // byte handed to the transmitter, no done yet

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			in_flight <= 1'b0;
		else if (tx_start)
			in_flight <= 1'b1;
		else if (tx_done)
			in_flight <= 1'b0;
	end

	////////////////////
	// serial handshake
	////////////////////
	a_start_idle: assert property (@(posedge clk) disable iff (!arst_n)
		tx_start |-> !in_flight)
		else begin
			fail_count++;
			$error("tx_start raised while a byte was still in flight");
		end

	////////////////////
	// core control
	////////////////////
	// once halted, only a clear lets the core run again
	a_no_run_halted: assert property (@(posedge clk) disable iff (!arst_n)
		halted && !core_clear |=> !core_en)
		else begin
			fail_count++;
			$error("core_en high while the core is halted");
		end

	a_we_in_load: assert property (@(posedge clk) disable iff (!arst_n)
		imem_we |-> in_load)
		else begin
			fail_count++;
			$error("imem_we high outside the load state");
		end

endmodule

// state compare is evaluated inside debug_unit
bind debug_unit debug_top_asserts i_asserts (
	.clk        (clk),
	.arst_n     (arst_n),
	.tx_start   (tx_start),
	.tx_done    (tx_done),
	.core_en    (core_en),
	.core_clear (core_clear),
	.halted     (halted),
	.imem_we    (imem_we),
	.in_load    (state == S_LOAD_BYTES)
);

//--- testbench/tb_debug_top.sv
module tb_debug_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD     = 8;
	localparam int CPB            = 8;      // clocks per serial bit
	localparam int IMEM_DEPTH     = 32;
	localparam int MAX_LEN        = 30;
	localparam int N_PROGS        = 8;
	localparam int N_TESTS        = N_PROGS + 6;   // random runs plus directed ones
	localparam int BYTES_PER_TEST = 3 + 4 * MAX_LEN + dbg_pkg::DUMP_BYTES;
	localparam longint WATCHDOG_NS =
		longint'(N_TESTS) * BYTES_PER_TEST * 10 * CPB * CLK_PERIOD * 4;
	localparam int FIRST_WAIT     = 12 * CPB + 4 * IMEM_DEPTH + 32;   // cycles
	localparam int BYTE_WAIT      = 2 * CPB + 16;

	logic clk;
	logic arst_n;
	logic rx;
	logic tx;

	int          value_errors;
	int          proto_errors;
	int          assert_errors;
	logic [31:0] lfsr;

	dbg_pkg::word_t prog      [MAX_LEN];
	dbg_pkg::word_t m_mem     [IMEM_DEPTH];
	dbg_pkg::word_t m_regs    [dbg_pkg::N_REGS];
	int             m_pc;
	bit             m_halted;
	dbg_pkg::byte_t dump_buf  [dbg_pkg::DUMP_BYTES];
	bit             dump_ok;

	debug_top #(.CLKS_PER_BIT(CPB), .IMEM_DEPTH(IMEM_DEPTH)) i_dut (
		.clk    (clk),
		.arst_n (arst_n),
		.rx     (rx),
		.tx     (tx)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("TESTS FAILED");
		$finish;
	end

	////////////////////
	// random source
	////////////////////
	function automatic logic next_bit();
		logic out;
		out  = lfsr[0];
		lfsr = lfsr >> 1;
		if (out)
			lfsr = lfsr ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++)
			v[i] = next_bit();
		return v;
	endfunction

	function automatic dbg_pkg::word_t encode(logic [3:0] op, int rd, int rs, int rt,
			logic [15:0] imm);
		dbg_pkg::word_t w;
		w        = '0;
		w[31:28] = op;
		w[26:24] = 3'(rd);
		w[22:20] = 3'(rs);
		w[18:16] = 3'(rt);
		w[15:0]  = imm;
		return w;
	endfunction

	function automatic dbg_pkg::word_t rand_instr();
		logic [2:0]     kind;
		logic [3:0]     op;
		dbg_pkg::word_t w;
		kind = 3'(rand_bits(3));
		case (kind)
			3'd0, 3'd4: op = dbg_pkg::OP_ADDI;
			3'd1, 3'd5: op = dbg_pkg::OP_ADD;
			3'd2:       op = dbg_pkg::OP_SUB;
			3'd3:       op = dbg_pkg::OP_XOR;
			3'd6:       op = 4'd4 + 4'(rand_bits(3));   // undefined 4..11
			default:    op = dbg_pkg::OP_ADDI;
		endcase
		w        = 32'(rand_bits(28));   // fields and spare bits all random
		w[31:28] = op;
		return w;
	endfunction

	function automatic void gen_program(int len);
		int i;
		for (i = 0; i < len - 1; i++)
			prog[i] = rand_instr();
		prog[len-1]        = 32'(rand_bits(28));
		prog[len-1][31:28] = dbg_pkg::OP_HALT;
	endfunction

	////////////////////
	// reference model
	////////////////////
	function automatic void model_reset();
		int i;
		for (i = 0; i < IMEM_DEPTH; i++)
			m_mem[i] = {dbg_pkg::OP_HALT, 28'd0};
		for (i = 0; i < dbg_pkg::N_REGS; i++)
			m_regs[i] = '0;
		m_pc     = 0;
		m_halted = 1'b0;
	endfunction

	function automatic void model_load(int len);
		int i;
		for (i = 0; i < len; i++)
			m_mem[i] = prog[i];
		m_pc     = 0;   // registers are kept
		m_halted = 1'b0;
	endfunction

	// executes one instruction, returns the cycles spent
	function automatic int model_step();
		dbg_pkg::word_t ins;
		dbg_pkg::word_t a;
		dbg_pkg::word_t b;
		dbg_pkg::word_t res;
		logic [3:0]     op;
		int             rd;
		bit             wr;
		if (m_halted)
			return 0;
		ins = m_mem[m_pc];
		op  = ins[31:28];
		rd  = ins[26:24];
		a   = m_regs[ins[22:20]];
		b   = m_regs[ins[18:16]];
		res = '0;
		wr  = 1'b1;
		case (op)
			dbg_pkg::OP_ADDI: res = a + {{16{ins[15]}}, ins[15:0]};
			dbg_pkg::OP_ADD:  res = a + b;
			dbg_pkg::OP_SUB:  res = a - b;
			dbg_pkg::OP_XOR:  res = a ^ b;
			dbg_pkg::OP_HALT: begin
				m_halted = 1'b1;   // pc stays put
				return 1;
			end
			default: wr = 1'b0;
		endcase
		if (wr && rd != 0)
			m_regs[rd] = res;
		m_pc = (m_pc + 1) % IMEM_DEPTH;
		return 1;
	endfunction

	function automatic int model_run();
		int n;
		n = 0;
		while (!m_halted && n < 4 * IMEM_DEPTH)
			n += model_step();
		return n;
	endfunction

	// expected raw dump byte from the model state
	function automatic dbg_pkg::byte_t model_dump_byte(int i, int count);
		dbg_pkg::word_t w;
		if (i / 4 < dbg_pkg::N_REGS)
			w = m_regs[i / 4];
		else if (i / 4 == dbg_pkg::N_REGS)
			w = dbg_pkg::word_t'(m_pc);
		else
			w = dbg_pkg::word_t'(count);
		return w[8 * (i % 4) +: 8];
	endfunction

	////////////////////
	// compare tasks
	////////////////////
	task automatic check_word(string name, dbg_pkg::word_t exp, dbg_pkg::word_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %08h, actual %08h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_byte(string name, dbg_pkg::byte_t exp, dbg_pkg::byte_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %02h, actual %02h", name, exp, act);
			value_errors++;
		end
	endtask

	////////////////////
	// host model
	////////////////////
	task automatic send_byte(dbg_pkg::byte_t b);
		logic [9:0] frame;
		int         i;
		frame = {1'b1, b, 1'b0};
		@(negedge clk);
		for (i = 0; i < 10; i++) begin
			rx = frame[i];
			repeat (CPB) @(negedge clk);
		end
	endtask

	task automatic get_byte(output dbg_pkg::byte_t b, output bit ok, input int limit);
		int n;
		int i;
		bit seen;
		n    = 0;
		seen = 1'b0;
		b    = '0;
		ok   = 1'b0;
		while (!seen && n < limit) begin
			@(negedge clk);
			seen = (tx === 1'b0);
			n++;
		end
		if (seen) begin
			repeat (CPB / 2 - 1) @(negedge clk);   // middle of start bit
			if (tx !== 1'b0) begin
				$display("start bit on tx ended before its middle");
				proto_errors++;
			end
			for (i = 0; i < 8; i++) begin
				repeat (CPB) @(negedge clk);
				b[i] = tx;
			end
			repeat (CPB) @(negedge clk);
			if (tx !== 1'b1) begin
				$display("stop bit on tx was low");
				proto_errors++;
			end
			ok = 1'b1;
		end
	endtask

	task automatic get_dump(string name);
		int i;
		bit ok;
		dump_ok = 1'b1;
		i       = 0;
		while (dump_ok && i < dbg_pkg::DUMP_BYTES) begin
			get_byte(dump_buf[i], ok, (i == 0) ? FIRST_WAIT : BYTE_WAIT);
			if (!ok) begin
				$display("%s: dump byte %0d of %0d never arrived on tx",
					name, i, dbg_pkg::DUMP_BYTES);
				proto_errors++;
				dump_ok = 1'b0;
			end
			i++;
		end
	endtask

	// the dump can start before the command's stop bit is over
	task automatic transact(dbg_pkg::byte_t cmd, string name);
		fork
			send_byte(cmd);
			get_dump(name);
		join
	endtask

	task automatic load_program(int len);
		int w;
		int k;
		send_byte(dbg_pkg::CMD_LOAD);
		send_byte(8'(len));
		for (w = 0; w < len; w++)
			for (k = 0; k < 4; k++)
				send_byte(prog[w][8*k +: 8]);   // lsb first
		model_load(len);
	endtask

	task automatic watch_idle(int cycles, string what);
		bit reported;
		reported = 1'b0;
		repeat (cycles) begin
			@(negedge clk);
			if (tx !== 1'b1 && !reported) begin
				$display("tx left idle during %s", what);
				proto_errors++;
				reported = 1'b1;
			end
		end
	endtask

	function automatic dbg_pkg::word_t dump_word(int w);
		return {dump_buf[4*w+3], dump_buf[4*w+2], dump_buf[4*w+1], dump_buf[4*w]};
	endfunction

	task automatic check_dump(string name, int exp_count);
		int r;
		if (dump_ok) begin
			for (r = 0; r < dbg_pkg::N_REGS; r++)
				check_word($sformatf("%s r%0d", name, r), m_regs[r], dump_word(r));
			check_word({name, " pc"}, dbg_pkg::word_t'(m_pc), dump_word(dbg_pkg::N_REGS));
			check_word({name, " count"}, dbg_pkg::word_t'(exp_count),
				dump_word(dbg_pkg::N_REGS + 1));
		end
	endtask

	////////////////////
	// test sequence
	////////////////////
	initial begin
		int p;
		int n;
		int i;
		int len;
		int cnt;
		rx           = 1'b1;
		arst_n       = 1'b0;
		lfsr         = 32'h5dec;
		value_errors = 0;
		proto_errors = 0;
		model_reset();
		watch_idle(16, "reset");
		arst_n = 1'b1;
		watch_idle(4 * CPB, "idle after reset");

		// reset memory is all halt
		cnt = model_run();
		transact(dbg_pkg::CMD_RUN, "reset_run");
		check_dump("reset_run", cnt);

		for (p = 0; p < N_PROGS; p++) begin
			len = (p == 0) ? MAX_LEN : 1 + int'(rand_bits(5)) % MAX_LEN;
			gen_program(len);
			load_program(len);
			cnt = model_run();
			transact(dbg_pkg::CMD_RUN, $sformatf("prog%0d_run", p));
			check_dump($sformatf("prog%0d_run", p), cnt);
		end

		// single steps up to and past the halt
		len = 2 + int'(rand_bits(3));
		gen_program(len);
		load_program(len);
		n = 0;
		while (!m_halted && n < MAX_LEN) begin
			cnt = model_step();
			transact(dbg_pkg::CMD_STEP, $sformatf("step%0d", n));
			check_dump($sformatf("step%0d", n), cnt);
			n++;
		end
		cnt = model_step();
		transact(dbg_pkg::CMD_STEP, "step_after_halt");
		check_dump("step_after_halt", cnt);
		if (dump_ok)
			for (i = 0; i < dbg_pkg::DUMP_BYTES; i++)
				check_byte($sformatf("step_after_halt byte%0d", i),
					model_dump_byte(i, cnt), dump_buf[i]);

		// r0 writes and undefined opcodes
		prog[0] = encode(dbg_pkg::OP_ADDI, 0, 0, 0, 16'h1234);
		prog[1] = encode(dbg_pkg::OP_ADDI, 1, 0, 0, 16'hfff0);
		prog[2] = encode(dbg_pkg::OP_ADDI, 2, 1, 0, 16'h0025);
		prog[3] = encode(4'h7, 1, 2, 2, 16'h7fff);
		prog[4] = encode(4'hc, 2, 1, 1, 16'h0001);
		prog[5] = encode(dbg_pkg::OP_ADD, 0, 1, 2, 16'h0000);
		prog[6] = encode(dbg_pkg::OP_XOR, 3, 1, 2, 16'h0000);
		prog[7] = encode(dbg_pkg::OP_SUB, 4, 0, 2, 16'h0000);
		prog[8] = encode(4'he, 5, 3, 4, 16'hffff);
		prog[9] = encode(dbg_pkg::OP_HALT, 0, 0, 0, 16'h0000);
		load_program(10);
		cnt = model_run();
		transact(dbg_pkg::CMD_RUN, "r0_undef");
		check_dump("r0_undef", cnt);

		// junk commands stay silent
		send_byte(8'h78);
		watch_idle(20 * CPB, "unknown command 78");
		send_byte(8'h00);
		watch_idle(20 * CPB, "unknown command 00");
		send_byte(8'hff);
		watch_idle(20 * CPB, "unknown command ff");
		send_byte(8'h72);
		watch_idle(20 * CPB, "unknown command 72");
		gen_program(6);
		load_program(6);
		cnt = model_run();
		transact(dbg_pkg::CMD_RUN, "after_unknown");
		check_dump("after_unknown", cnt);

		// shorter reload keeps the registers
		gen_program(24);
		load_program(24);
		cnt = model_run();
		transact(dbg_pkg::CMD_RUN, "reload_long_run");
		check_dump("reload_long_run", cnt);
		gen_program(4);
		load_program(4);
		cnt = model_run();
		transact(dbg_pkg::CMD_RUN, "reload_short_run");
		check_dump("reload_short_run", cnt);

		assert_errors = i_dut.i_debug_unit.i_asserts.fail_count;
		$display("errors: %0d value, %0d protocol, %0d assertion",
			value_errors, proto_errors, assert_errors);
		if (value_errors == 0 && proto_errors == 0 && assert_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- build.f
hw/dbg_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/inst_mem.sv
hw/mini_core.sv
hw/debug_unit.sv
hw/debug_top.sv
testbench/debug_top_asserts.sv
testbench/tb_debug_top.sv

//--- Bender.yml
package:
  name: debug_top

sources:
  - hw/dbg_pkg.sv
  - hw/uart_rx.sv
  - hw/uart_tx.sv
  - hw/inst_mem.sv
  - hw/mini_core.sv
  - hw/debug_unit.sv
  - hw/debug_top.sv
  - target: test
    files:
      - testbench/debug_top_asserts.sv
      - testbench/tb_debug_top.sv
